// File: all.f
hdl/ioWritePkg.sv
hdl/ioCheck.sv
hdl/ioActive.sv
hdl/writeIssue.sv
hdl/ioWrite.sv
hdl/writePortBuffer.sv
hdl/dataMemory.sv
hdl/ioWriteTop.sv
dv/ioWrite_asserts.sv
dv/ioWriteTb.sv

// File: dv/ioWriteTb.sv
// Self-checking testbench for ioWriteTop with seeded random traffic and a reference model
// RAM contents are undefined after reset, so the model copies them once before any write
module ioWriteTb;

    timeunit 1ns;
    timeprecision 1ps;

    import ioWritePkg::*;

    // Handshakes in tests 2 to 5
    localparam int totalHandshakes = 4 + 8 + 5 + 200;
    localparam int timeoutCycles = 20 * totalHandshakes * 10;

    logic                                clock = 1'b0;
    logic                                reset;
    logic                                inReq;
    logic                                inAck;
    writeOpT                             op;
    logic [portCount-1:0]                outReq;
    logic [portCount-1:0]                outAck;
    logic [portCount-1:0][wordWidth-1:0] outData;
    logic [addrWidth-1:0]                readAddr;
    logic [wordWidth-1:0]                readData;

    integer               seed;
    logic [wordWidth-1:0] modelRam [1 << addrWidth];
    logic [wordWidth-1:0] portModel [portCount][$];
    int                   drainIdx [portCount];
    int                   drainDelays [256];
    logic [portCount-1:0] drainEnable;
    bit                   drainRandom;
    int                   errorCount;
    int                   drainErrors;
    int                   testErrorBase;
    int                   testsRun;
    int                   cycleCount;

    ioWriteTop DUT (
        .clock    (clock),
        .reset    (reset),
        .inReq    (inReq),
        .inAck    (inAck),
        .op       (op),
        .outReq   (outReq),
        .outAck   (outAck),
        .outData  (outData),
        .readAddr (readAddr),
        .readData (readData)
    );

    always #5 clock = ~clock;

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual, inout int errors);
        if (expected !== actual) begin
            $display("[FAIL] %s: expected %0h, actual %0h", name, expected, actual);
            errors++;
        end
    endtask

    function automatic bit isPortAddr(input logic [addrWidth-1:0] addr);
        return addr >= 8'hF0 && addr <= 8'hF3;
    endfunction

    // Opcode rule: wrapping add, sub and xor, and pass forwards operand a
    function automatic logic [wordWidth-1:0] expectedResult(input writeOpT o);
        case (o.opcode)
            opAdd:   return o.a + o.b;
            opSub:   return o.a - o.b;
            opXor:   return o.a ^ o.b;
            default: return o.a;
        endcase
    endfunction

    task automatic applyModel(input writeOpT o);
        if (isPortAddr(o.addr)) begin
            portModel[o.addr[1:0]].push_back(expectedResult(o));
        end else begin
            modelRam[o.addr] = expectedResult(o);
        end
    endtask

    task automatic makeRandomOp(input bit toPort, output writeOpT o);
        o.opcode = opcodeT'(2'($random(seed)));
        o.a = 16'($random(seed));
        o.b = 16'($random(seed));
        o.addr = 8'($random(seed));
        if (toPort) begin
            o.addr = 8'hF0 | (o.addr & 8'h03);
        end else if (isPortAddr(o.addr)) begin
            o.addr = o.addr & 8'h7F;
        end
    endtask

    // Leaves inReq high when no ack came within the limit
    task automatic issueOp(input writeOpT o, input int limit, output bit acked);
        int waited;
        waited = 0;
        acked = 1'b0;
        op = o;
        inReq = 1'b1;
        while (!acked && waited < limit) begin
            @(posedge clock);
            #1;
            waited++;
            acked = inAck;
        end
        if (acked) begin
            applyModel(o);
            inReq = 1'b0;
        end
    endtask

    task automatic releaseAck();
        int waited;
        waited = 0;
        while (inAck && waited < 50) begin
            @(posedge clock);
            #1;
            waited++;
        end
        if (inAck) begin
            $display("inAck stayed high after inReq was dropped");
            errorCount++;
        end
    endtask

    task automatic sendOp(input writeOpT o);
        bit acked;
        issueOp(o, 500, acked);
        if (!acked) begin
            $display("No inAck for a write to address %0h", o.addr);
            errorCount++;
            inReq = 1'b0;
        end
        releaseAck();
    endtask

    task automatic waitDrained(input int limit);
        int waited;
        int pending;
        waited = 0;
        pending = 1;
        while (pending != 0 && waited < limit) begin
            @(posedge clock);
            #1;
            waited++;
            pending = 0;
            for (int p = 0; p < portCount; p++) begin
                pending += portModel[p].size() - drainIdx[p];
            end
        end
        if (pending != 0) begin
            $display("Port buffers still held %0d words after %0d cycles", pending, limit);
            errorCount++;
        end
    endtask

    // With copy set the model takes the RAM contents, otherwise they are compared
    task automatic scanRam(input string name, input bit copy);
        for (int a = 0; a < (1 << addrWidth); a++) begin
            @(posedge clock);
            #1;
            readAddr = 8'(a);
            #1;
            if (copy) begin
                modelRam[a] = readData;
            end else begin
                checkValue($sformatf("%s at %0h", name, a), 32'(modelRam[a]),
                           32'(readData), errorCount);
            end
        end
        @(posedge clock);
        #1;
    endtask

    task automatic endTest(input string name);
        int errs;
        errs = errorCount + drainErrors - testErrorBase;
        testsRun++;
        $display("Test %0d (%s) finished with %0d errors", testsRun, name, errs);
        testErrorBase = errorCount + drainErrors;
    endtask

    // Drain side of every port, acking each offered word after an optional random delay
    initial begin
        int phase [portCount];
        int countdown [portCount];
        int delayIdx;
        outAck = '0;
        delayIdx = 0;
        for (int p = 0; p < portCount; p++) begin
            phase[p] = 0;
            countdown[p] = 0;
            drainIdx[p] = 0;
        end
        forever begin
            @(posedge clock);
            #1;
            for (int p = 0; p < portCount; p++) begin
                if (phase[p] == 0) begin
                    if (drainEnable[p] && outReq[p]) begin
                        countdown[p] = drainRandom ? drainDelays[delayIdx % 256] : 0;
                        delayIdx++;
                        phase[p] = 1;
                    end
                end else if (phase[p] == 1) begin
                    if (countdown[p] > 0) begin
                        countdown[p]--;
                    end else begin
                        if (drainIdx[p] >= portModel[p].size()) begin
                            $display("Port %0d offered a word with no write pending for it", p);
                            drainErrors++;
                        end else begin
                            checkValue($sformatf("port %0d word %0d", p, drainIdx[p]),
                                       32'(portModel[p][drainIdx[p]]), 32'(outData[p]),
                                       drainErrors);
                        end
                        drainIdx[p]++;
                        outAck[p] = 1'b1;
                        phase[p] = 2;
                    end
                end else if (!outReq[p]) begin
                    outAck[p] = 1'b0;
                    phase[p] = 0;
                end
            end
        end
    end

    initial begin
        cycleCount = 0;
        while (cycleCount < timeoutCycles) begin
            @(posedge clock);
            cycleCount++;
        end
        $display("Run stopped after %0d cycles without finishing", timeoutCycles);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        writeOpT o;
        bit      acked;
        int      busyCycles;
        int      startIdx;
        seed = 32'h1626;
        reset = 1'b1;
        inReq = 1'b0;
        op = '0;
        readAddr = '0;
        drainEnable = '1;
        drainRandom = 1'b0;
        errorCount = 0;
        drainErrors = 0;
        testErrorBase = 0;
        testsRun = 0;
        for (int i = 0; i < 256; i++) begin
            drainDelays[i] = $random(seed) & 7;
        end
        repeat (5) @(posedge clock);
        #1;
        reset = 1'b0;

        checkValue("reset inAck", 0, 32'(inAck), errorCount);
        checkValue("reset outReq", 0, 32'(outReq), errorCount);
        busyCycles = 0;
        repeat (20) begin
            @(posedge clock);
            #1;
            if (outReq != '0) busyCycles++;
        end
        checkValue("idle outReq cycles", 0, 32'(busyCycles), errorCount);
        endTest("reset state");

        // Operands chosen so that add and sub both wrap
        scanRam("ram snapshot", 1'b1);
        for (int k = 0; k < 4; k++) begin
            o.opcode = opcodeT'(2'(k));
            o.addr = 8'h10 + 8'(k);
            o.a = (k == 1) ? 16'h0003 : 16'hFFF0;
            o.b = 16'h0035;
            issueOp(o, 100, acked);
            checkValue("ram write acked", 1, 32'(acked), errorCount);
            repeat (3) @(posedge clock);
            #1;
            readAddr = o.addr;
            #1;
            checkValue($sformatf("%s result", o.opcode.name()), 32'(expectedResult(o)),
                       32'(readData), errorCount);
            @(posedge clock);
            #1;
            releaseAck();
        end
        endTest("opcode results");

        for (int k = 0; k < 8; k++) begin
            makeRandomOp(1'b1, o);
            o.addr = 8'hF0 + 8'(k % 4);
            sendOp(o);
        end
        waitDrained(200);
        for (int p = 0; p < portCount; p++) begin
            checkValue($sformatf("port %0d word count", p), 2, 32'(drainIdx[p]), errorCount);
        end
        scanRam("ram after port writes", 1'b0);
        endTest("port routing");

        drainEnable[2] = 1'b0;
        startIdx = drainIdx[2];
        for (int k = 0; k < 4; k++) begin
            makeRandomOp(1'b1, o);
            o.addr = 8'hF2;
            sendOp(o);
        end
        makeRandomOp(1'b1, o);
        o.addr = 8'hF2;
        issueOp(o, 30, acked);
        checkValue("fifth write acked while port 2 full", 0, 32'(acked), errorCount);
        drainEnable[2] = 1'b1;
        for (int w = 0; w < 50 && drainIdx[2] == startIdx; w++) begin
            @(posedge clock);
            #1;
        end
        drainEnable[2] = 1'b0;
        issueOp(o, 50, acked);
        checkValue("fifth write acked after one drain", 1, 32'(acked), errorCount);
        releaseAck();
        drainEnable[2] = 1'b1;
        waitDrained(200);
        checkValue("port 2 words drained", 5, 32'(drainIdx[2] - startIdx), errorCount);
        endTest("port full stall");

        drainRandom = 1'b1;
        for (int k = 0; k < 200; k++) begin
            makeRandomOp(($random(seed) & 1) == 1, o);
            sendOp(o);
        end
        waitDrained(500);
        scanRam("ram after random writes", 1'b0);
        endTest("random traffic");

        $display("%0d tests run, %0d errors", testsRun, errorCount + drainErrors);
        if (errorCount + drainErrors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: dv/ioWrite_asserts.sv
// Handshake and port-write checks bound into ioWriteTop, idle while reset is high
// Uses the internal portWrite and portFull nets of the top level
module ioWriteAsserts (
    input logic                                clock,
    input logic                                reset,
    input logic                                inReq,
    input logic                                inAck,
    input logic [ioWritePkg::portCount-1:0]    outReq,
    input logic [ioWritePkg::portCount-1:0]    outAck,
    input logic [ioWritePkg::portCount-1:0]    portWrite,
    input logic [ioWritePkg::portCount-1:0]    portFull
);

    timeunit 1ns;
    timeprecision 1ps;

    import ioWritePkg::*;

    // The ack answers a request that was up at the capture edge
    ackNeedsReq: assert property (@(posedge clock) disable iff (reset)
        $rose(inAck) |-> $past(inReq))
        else $error("inAck rose without inReq");

    for (genvar p = 0; p < portCount; p++) begin : drainLink
        reqHeld: assert property (@(posedge clock) disable iff (reset)
            outReq[p] && !outAck[p] |=> outReq[p])
            else $error("outReq[%0d] dropped before outAck", p);
    end

    portWriteOneHot: assert property (@(posedge clock) disable iff (reset)
        $onehot0(portWrite))
        else $error("portWrite has more than one bit set");

    noWriteWhenFull: assert property (@(posedge clock) disable iff (reset)
        (portWrite & portFull) == '0)
        else $error("Port write into a full port buffer");

endmodule

bind ioWriteTop ioWriteAsserts protocolChecks (
    .clock     (clock),
    .reset     (reset),
    .inReq     (inReq),
    .inAck     (inAck),
    .outReq    (outReq),
    .outAck    (outAck),
    .portWrite (portWrite),
    .portFull  (portFull)
);

// File: hdl/dataMemory.sv
// Data RAM with a synchronous write and an asynchronous read port
// Contents are not cleared by reset
module dataMemory (
    input  logic                                clock,
    input  ioWritePkg::memWriteT                memWrite,
    input  logic [ioWritePkg::addrWidth-1:0]    readAddr,
    output logic [ioWritePkg::wordWidth-1:0]    readData
);

    import ioWritePkg::*;

    localparam int ramWords = 1 << addrWidth;

    logic [wordWidth-1:0] ram [ramWords];

    // The mapping block only enables writes for non-port addresses
    always_ff @(posedge clock) begin
        if (memWrite.enable) begin
            ram[memWrite.addr] <= memWrite.data;
        end
    end

    assign readData = ram[readAddr];

endmodule

// File: hdl/ioActive.sv
// Registered one-hot port enable for a result leaving the pipeline
// Output is all zeros when isIo is low
module ioActive (
    input  logic                                clock,
    input  logic                                isIo,
    input  logic [ioWritePkg::addrWidth-1:0]    addr,
    output logic [ioWritePkg::portCount-1:0]    active
);

    import ioWritePkg::*;

    logic [portCount-1:0] portSelect;

    always_comb begin
        portSelect = '0;
        if (isIo) begin
            portSelect[addr[portAddrWidth-1:0]] = 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        active <= portSelect;
    end

endmodule

// File: hdl/ioCheck.sv
// Address decode and full-flag select for the producer's capture decision
// Outputs are combinational from addr, with a one-cycle hold on a port leaving full
module ioCheck (
    input  logic                                clock,
    input  logic [ioWritePkg::addrWidth-1:0]    addr,
    input  logic [ioWritePkg::portCount-1:0]    portFull,
    output logic                                addrIsIo,
    output logic                                portBlocked
);

    import ioWritePkg::*;

    logic [portAddrWidth-1:0] portIdx;
    logic [portCount-1:0]     fullLast;

    // The upper address bits identify the port window
    assign addrIsIo = addr[addrWidth-1:portAddrWidth]
                      == portBaseAddr[addrWidth-1:portAddrWidth];

    assign portIdx = addr[portAddrWidth-1:0];

    // A port stays blocked for one cycle after it drops below full, so the
    // slot freed by a pop has settled before a capture relies on it
    always_ff @(posedge clock) begin
        fullLast <= portFull;
    end

    // RAM addresses are never blocked
    assign portBlocked = addrIsIo && (portFull[portIdx] || fullLast[portIdx]);

endmodule

// File: hdl/ioWrite.sv
// Maps a finished result onto a RAM write or a one-hot port write
// Port addresses never reach the RAM, and RAM writes never enable a port
module ioWrite (
    input  logic                                clock,
    input  logic                                reset,
    input  ioWritePkg::resultT                  result,
    input  logic                                resultValid,
    output ioWritePkg::memWriteT                memWrite,
    output logic [ioWritePkg::portCount-1:0]    portWrite,
    output logic [ioWritePkg::wordWidth-1:0]    portData
);

    import ioWritePkg::*;

    logic                 ramEnable;
    logic [addrWidth-1:0] ramAddr;
    logic [wordWidth-1:0] ramData;
    logic                 ioValid;

    // The I/O flag rides with the result from the producer
    assign ioValid = resultValid && result.isIo;

    always_ff @(posedge clock) begin
        if (reset) begin
            ramEnable <= 1'b0;
        end else begin
            ramEnable <= resultValid && !result.isIo;
        end
    end

    always_ff @(posedge clock) begin
        ramAddr <= result.addr;
        ramData <= result.data;
    end

    assign memWrite = '{enable: ramEnable, addr: ramAddr, data: ramData};

    // One data register feeds all four ports; the enable picks the target
    always_ff @(posedge clock) begin
        portData <= result.data;
    end

    // Registered inside ioActive, so the enable lines up with portData
    ioActive active (
        .clock  (clock),
        .isIo   (ioValid),
        .addr   (result.addr),
        .active (portWrite)
    );

endmodule

// File: hdl/ioWritePkg.sv
// Shared widths, port map and types for the write side of the pipeline
// portDepth must be a power of two because the FIFO pointers wrap naturally
package ioWritePkg;

    localparam int wordWidth = 16;
    localparam int addrWidth = 8;

    // Output ports sit at F0 to F3, everything else is RAM
    localparam int portCount = 4;
    localparam int portAddrWidth = 2;
    localparam logic [addrWidth-1:0] portBaseAddr = 8'hF0;

    localparam int portDepth = 4;
    localparam int portPtrWidth = $clog2(portDepth);
    localparam int portLevelWidth = $clog2(portDepth + 1);

    // opPass writes operand a, arithmetic wraps at the word width
    typedef enum logic [1:0] {
        opAdd,
        opSub,
        opXor,
        opPass
    } opcodeT;

    typedef struct packed {
        opcodeT                 opcode;
        logic [addrWidth-1:0]   addr;
        logic [wordWidth-1:0]   a;
        logic [wordWidth-1:0]   b;
    } writeOpT;

    typedef struct packed {
        logic [addrWidth-1:0]   addr;
        logic [wordWidth-1:0]   data;
        logic                   isIo;
    } resultT;

    typedef struct packed {
        logic                   enable;
        logic [addrWidth-1:0]   addr;
        logic [wordWidth-1:0]   data;
    } memWriteT;

endpackage

// File: hdl/ioWriteTop.sv
// Write-side top level: producer, write mapping, data RAM and port buffers
// A write is visible 3 clock edges after the edge that raises inAck
module ioWriteTop (
    input  logic                                                    clock,
    input  logic                                                    reset,
    input  logic                                                    inReq,
    output logic                                                    inAck,
    input  ioWritePkg::writeOpT                                     op,
    output logic [ioWritePkg::portCount-1:0]                        outReq,
    input  logic [ioWritePkg::portCount-1:0]                        outAck,
    output logic [ioWritePkg::portCount-1:0][ioWritePkg::wordWidth-1:0] outData,
    input  logic [ioWritePkg::addrWidth-1:0]                        readAddr,
    output logic [ioWritePkg::wordWidth-1:0]                        readData
);

    import ioWritePkg::*;

    logic [portCount-1:0] portFull;
    resultT               result;
    logic                 resultValid;
    memWriteT             memWrite;
    logic [portCount-1:0] portWrite;
    logic [wordWidth-1:0] portData;

    writeIssue issue (
        .clock       (clock),
        .reset       (reset),
        .inReq       (inReq),
        .inAck       (inAck),
        .op          (op),
        .portFull    (portFull),
        .result      (result),
        .resultValid (resultValid)
    );

    ioWrite mapping (
        .clock       (clock),
        .reset       (reset),
        .result      (result),
        .resultValid (resultValid),
        .memWrite    (memWrite),
        .portWrite   (portWrite),
        .portData    (portData)
    );

    dataMemory memory (
        .clock    (clock),
        .memWrite (memWrite),
        .readAddr (readAddr),
        .readData (readData)
    );

    writePortBuffer buffer (
        .clock     (clock),
        .reset     (reset),
        .portWrite (portWrite),
        .portData  (portData),
        .portFull  (portFull),
        .outReq    (outReq),
        .outAck    (outAck),
        .outData   (outData)
    );

endmodule

// File: hdl/writeIssue.sv
// Producer stage with a four-phase req/ack input link
// A write to a full port holds off inAck until that port has room
module writeIssue (
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                inReq,
    output logic                                inAck,
    input  ioWritePkg::writeOpT                 op,
    input  logic [ioWritePkg::portCount-1:0]    portFull,
    output ioWritePkg::resultT                  result,
    output logic                                resultValid
);

    import ioWritePkg::*;

    typedef enum logic [1:0] {
        idle,
        ackHigh,
        waitDrop
    } handshakeStateT;

    handshakeStateT       state;
    logic                 addrIsIo;
    logic                 portBlocked;
    logic                 capture;
    writeOpT              capOp;
    logic                 capIsIo;
    logic                 capValid;
    logic [wordWidth-1:0] opResult;

    ioCheck check (
        .clock       (clock),
        .addr        (op.addr),
        .portFull    (portFull),
        .addrIsIo    (addrIsIo),
        .portBlocked (portBlocked)
    );

    assign capture = (state == idle) && inReq && !inAck && !portBlocked;

    // inAck is held until the previous write has left this stage, which keeps
    // every capture at least 4 cycles apart and the full flags exact
    always_ff @(posedge clock) begin
        if (reset) begin
            state <= idle;
            inAck <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (capture) begin
                        inAck <= 1'b1;
                        state <= ackHigh;
                    end
                end
                ackHigh: begin
                    if (!inReq) begin
                        state <= waitDrop;
                    end
                end
                waitDrop: begin
                    if (!capValid && !resultValid) begin
                        inAck <= 1'b0;
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            capValid    <= 1'b0;
            resultValid <= 1'b0;
        end else begin
            capValid    <= capture;
            resultValid <= capValid;
        end
    end

    always_comb begin
        opResult = capOp.a;
        case (capOp.opcode)
            opAdd:   opResult = capOp.a + capOp.b;
            opSub:   opResult = capOp.a - capOp.b;
            opXor:   opResult = capOp.a ^ capOp.b;
            opPass:  opResult = capOp.a;
            default: opResult = capOp.a;
        endcase
    end

    always_ff @(posedge clock) begin
        if (capture) begin
            capOp   <= op;
            capIsIo <= addrIsIo;
        end
        result.addr <= capOp.addr;
        result.data <= opResult;
        result.isIo <= capIsIo;
    end

endmodule

// File: hdl/writePortBuffer.sv
// One FIFO per output port, each drained over its own four-phase req/ack link
// A write to a full port is not guarded here; the producer must stall on portFull
module writePortBuffer (
    input  logic                                                    clock,
    input  logic                                                    reset,
    input  logic [ioWritePkg::portCount-1:0]                        portWrite,
    input  logic [ioWritePkg::wordWidth-1:0]                        portData,
    output logic [ioWritePkg::portCount-1:0]                        portFull,
    output logic [ioWritePkg::portCount-1:0]                        outReq,
    input  logic [ioWritePkg::portCount-1:0]                        outAck,
    output logic [ioWritePkg::portCount-1:0][ioWritePkg::wordWidth-1:0] outData
);

    import ioWritePkg::*;

    typedef enum logic [1:0] {
        drainIdle,
        drainReq,
        drainRelease
    } drainStateT;

    for (genvar p = 0; p < portCount; p++) begin : port
        logic [wordWidth-1:0]      fifo [portDepth];
        logic [portPtrWidth-1:0]   wrPtr;
        logic [portPtrWidth-1:0]   rdPtr;
        logic [portLevelWidth-1:0] level;
        drainStateT                drainState;
        logic                      push;
        logic                      pop;

        assign push = portWrite[p];
        assign pop  = (drainState == drainReq) && outAck[p];

        assign portFull[p] = level == portLevelWidth'(portDepth);
        assign outReq[p]   = drainState == drainReq;

        // The head word is stable while outReq is high, since rdPtr moves on pop
        assign outData[p] = fifo[rdPtr];

        always_ff @(posedge clock) begin
            if (push) begin
                fifo[wrPtr] <= portData;
            end
        end

        always_ff @(posedge clock) begin
            if (reset) begin
                wrPtr <= '0;
                rdPtr <= '0;
                level <= '0;
            end else begin
                if (push) begin
                    wrPtr <= wrPtr + 1'b1;
                end
                if (pop) begin
                    rdPtr <= rdPtr + 1'b1;
                end
                if (push && !pop) begin
                    level <= level + 1'b1;
                end else if (pop && !push) begin
                    level <= level - 1'b1;
                end
            end
        end

        always_ff @(posedge clock) begin
            if (reset) begin
                drainState <= drainIdle;
            end else begin
                case (drainState)
                    drainIdle:    if (level != '0) drainState <= drainReq;
                    drainReq:     if (outAck[p]) drainState <= drainRelease;
                    drainRelease: if (!outAck[p]) drainState <= drainIdle;
                    default:      drainState <= drainIdle;
                endcase
            end
        end
    end

endmodule

// File: run.sh
#!/bin/sh
# Builds the ioWriteTb simulation with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"
verilator --binary --assert --timescale 1ns/1ps -j 0 --top-module ioWriteTb -f all.f \
    -o ioWriteSim
./obj_dir/ioWriteSim > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log
if grep -q "TESTS FAILED" sim.log; then
    echo "Simulation reported failures"
    exit 1
fi
echo "Simulation completed without failures"
